// File: common/page_cache_pkg.sv
`default_nettype none

package page_cache_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int WORD_BYTES = WORD_W / 8;

    // Page geometry, one resident page of 4 KiB
    localparam int WORDS_PER_PAGE = 1024;
    localparam int WORD_OFS_W = $clog2(WORD_BYTES);
    localparam int WORD_IDX_W = $clog2(WORDS_PER_PAGE);
    localparam int PAGE_OFS_W = WORD_IDX_W + WORD_OFS_W;
    localparam int PAGE_W = ADDR_W - PAGE_OFS_W;

    // Burst geometry, INCR bursts of four-byte beats
    localparam int BURST_BEATS = 32;
    localparam int BURST_BYTES = BURST_BEATS * WORD_BYTES;
    localparam int BURSTS_PER_PAGE = WORDS_PER_PAGE / BURST_BEATS;
    localparam int BEAT_CNT_W = $clog2(BURST_BEATS);
    localparam int BURST_CNT_W = $clog2(BURSTS_PER_PAGE);

    // Byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // Data word
    typedef logic [WORD_W-1:0] word_t;

    // Page number, upper address bits
    typedef logic [PAGE_W-1:0] page_t;

    // Word position inside a page
    typedef logic [WORD_IDX_W-1:0] word_idx_t;

    // Beat within a burst
    typedef logic [BEAT_CNT_W-1:0] beat_cnt_t;

    // Burst within a page fill
    typedef logic [BURST_CNT_W-1:0] burst_cnt_t;

    // Page fill FSM
    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_ADDR,
        FILL_DATA
    } fill_state_t;

endpackage

`default_nettype wire

// File: page_cache/page_cache_ram.sv
`timescale 1ns/100ps
`default_nettype none

module page_cache_ram
    import page_cache_pkg::*;
(
    input  logic       CLK,

    // Fill side
    input  logic       wr_en,
    input  word_idx_t  wr_idx,
    input  word_t      wr_data,

    // Requester side
    input  word_idx_t  rd_idx,
    output word_t      rd_data
);

    // One page of words
    word_t mem [WORDS_PER_PAGE];

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // Async read so a hit returns in the request cycle
    assign rd_data = mem[rd_idx];

endmodule

`default_nettype wire

// File: page_cache/page_fill_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module page_fill_ctrl
    import page_cache_pkg::*;
(
    input  logic       CLK,
    input  logic       RST,

    // Requester
    input  logic       rden,
    input  addr_t      raddr,
    output logic       rvalid,
    input  addr_t      hit_check_addr,
    output logic       hit_check_result,

    // AXI AR channel
    output addr_t      m_axi_araddr,
    output logic       m_axi_arvalid,
    input  logic       m_axi_arready,

    // AXI R channel
    input  word_t      m_axi_rdata,
    input  logic       m_axi_rlast,
    input  logic       m_axi_rvalid,

    // Array write port
    output logic       wr_en,
    output word_idx_t  wr_idx,
    output word_t      wr_data
);

    fill_state_t state;
    fill_state_t state_next;

    // Resident page
    page_t       tag_page;
    logic        tag_valid;

    // Page being fetched
    page_t       fill_page;
    burst_cnt_t  burst_cnt;
    beat_cnt_t   beat_cnt;

    page_t       req_page;
    page_t       chk_page;
    logic        hit;
    logic        miss;
    logic        fill_start;
    logic        beat_acc;
    logic        beat_last;
    logic        burst_end;
    logic        last_burst;
    addr_t       page_base;

    assign req_page = raddr[ADDR_W-1:PAGE_OFS_W];
    assign chk_page = hit_check_addr[ADDR_W-1:PAGE_OFS_W];

    // Tag compare for both address inputs
    assign hit = tag_valid && (req_page == tag_page);
    assign miss = rden && !hit;
    assign rvalid = rden && hit;
    assign hit_check_result = tag_valid && (chk_page == tag_page);

    assign fill_start = (state == FILL_IDLE) && miss;

    // R beats are never stalled
    assign beat_acc = (state == FILL_DATA) && m_axi_rvalid;
    assign beat_last = (beat_cnt == beat_cnt_t'(BURST_BEATS - 1));
    // Burst closes on rlast, or on the counted last beat if rlast is lost
    assign burst_end = beat_acc && (m_axi_rlast || beat_last);
    assign last_burst = (burst_cnt == burst_cnt_t'(BURSTS_PER_PAGE - 1));

    always_comb begin
        state_next = state;
        case (state)
            FILL_IDLE: begin
                if (miss) begin
                    state_next = FILL_ADDR;
                end
            end
            FILL_ADDR: begin
                if (m_axi_arready) begin
                    state_next = FILL_DATA;
                end
            end
            FILL_DATA: begin
                if (burst_end) begin
                    state_next = last_burst ? FILL_IDLE : FILL_ADDR;
                end
            end
            default: begin
                state_next = FILL_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= FILL_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // AR valid follows the next state, so it drops on the arready edge
    always_ff @(posedge CLK) begin
        if (RST) begin
            m_axi_arvalid <= 1'b0;
        end else begin
            m_axi_arvalid <= (state_next == FILL_ADDR);
        end
    end

    // Tag is dropped at fill start and set after the final beat
    always_ff @(posedge CLK) begin
        if (RST) begin
            tag_valid <= 1'b0;
        end else if (fill_start) begin
            tag_valid <= 1'b0;
        end else if (burst_end && last_burst) begin
            tag_valid <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (burst_end && last_burst) begin
            tag_page <= fill_page;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_start) begin
            fill_page <= req_page;
        end
    end

    // Burst counter
    always_ff @(posedge CLK) begin
        if (RST) begin
            burst_cnt <= '0;
        end else if (fill_start) begin
            burst_cnt <= '0;
        end else if (burst_end && !last_burst) begin
            burst_cnt <= burst_cnt + 1'b1;
        end
    end

    // Beat counter, restarts with every burst
    always_ff @(posedge CLK) begin
        if (RST) begin
            beat_cnt <= '0;
        end else if (fill_start || burst_end) begin
            beat_cnt <= '0;
        end else if (beat_acc) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // AR address, stable while burst_cnt holds in FILL_ADDR
    assign page_base = {fill_page, {PAGE_OFS_W{1'b0}}};
    assign m_axi_araddr = page_base + addr_t'(burst_cnt) * addr_t'(BURST_BYTES);

    assign wr_en = beat_acc;
    assign wr_idx = {burst_cnt, beat_cnt};
    assign wr_data = m_axi_rdata;

endmodule

`default_nettype wire

// File: src/cache_axi.sv
`timescale 1ns/100ps
`default_nettype none

module cache_axi
    import page_cache_pkg::*;
(
    input  logic   CLK,
    input  logic   RST,

    // Requester read port
    input  logic   rden,
    input  addr_t  raddr,
    output logic   rvalid,
    output word_t  rdata,

    // Hit check
    input  addr_t  hit_check_addr,
    output logic   hit_check_result,

    // AXI AR channel
    output addr_t  m_axi_araddr,
    output logic   m_axi_arvalid,
    input  logic   m_axi_arready,

    // AXI R channel
    input  word_t  m_axi_rdata,
    input  logic   m_axi_rlast,
    input  logic   m_axi_rvalid
);

    logic       wr_en;
    word_idx_t  wr_idx;
    word_t      wr_data;
    word_idx_t  rd_idx;

    // Word index within the page
    assign rd_idx = raddr[PAGE_OFS_W-1:WORD_OFS_W];

    page_fill_ctrl u_fill (
        .CLK              (CLK),
        .RST              (RST),
        .rden             (rden),
        .raddr            (raddr),
        .rvalid           (rvalid),
        .hit_check_addr   (hit_check_addr),
        .hit_check_result (hit_check_result),
        .m_axi_araddr     (m_axi_araddr),
        .m_axi_arvalid    (m_axi_arvalid),
        .m_axi_arready    (m_axi_arready),
        .m_axi_rdata      (m_axi_rdata),
        .m_axi_rlast      (m_axi_rlast),
        .m_axi_rvalid     (m_axi_rvalid),
        .wr_en            (wr_en),
        .wr_idx           (wr_idx),
        .wr_data          (wr_data)
    );

    page_cache_ram u_ram (
        .CLK     (CLK),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .rd_idx  (rd_idx),
        .rd_data (rdata)
    );

endmodule

`default_nettype wire

// File: bench/axi_rd_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module axi_rd_mem_model
    import page_cache_pkg::*;
(
    input  logic   CLK,
    input  logic   RST,
    input  word_t  key,

    // AR channel
    input  addr_t  araddr,
    input  logic   arvalid,
    output logic   arready,

    // R channel
    output word_t  rdata,
    output logic   rlast,
    output logic   rvalid
);

    // One AR handshake followed by one INCR burst
    task automatic serve_burst();
        addr_t base;
        int    wait_cycles;
        base = araddr;
        wait_cycles = $urandom_range(0, 3);
        repeat (wait_cycles) begin
            @(posedge CLK);
            #1;
        end
        arready = 1'b1;
        @(posedge CLK);
        #1;
        arready = 1'b0;
        for (int i = 0; i < BURST_BEATS; i++) begin
            wait_cycles = $urandom_range(0, 3);
            repeat (wait_cycles) begin
                @(posedge CLK);
                #1;
            end
            rvalid = 1'b1;
            rdata = word_t'(base + addr_t'(i * 4)) ^ key;
            rlast = (i == BURST_BEATS - 1);
            @(posedge CLK);
            #1;
            rvalid = 1'b0;
            rlast = 1'b0;
        end
    endtask

    initial begin
        arready = 1'b0;
        rvalid = 1'b0;
        rlast = 1'b0;
        rdata = '0;
        forever begin
            @(posedge CLK);
            #1;
            if (!RST && arvalid) begin
                serve_burst();
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/cache_axi_assert.sv
`timescale 1ns/100ps
`default_nettype none

module cache_axi_assert
    import page_cache_pkg::*;
(
    input  logic         CLK,
    input  logic         RST,
    input  logic         rvalid,
    input  addr_t        m_axi_araddr,
    input  logic         m_axi_arvalid,
    input  logic         m_axi_arready,
    input  fill_state_t  fill_state
);

    int fail_count = 0;

    // AR request held until accepted
    ar_hold: assert property (@(posedge CLK) disable iff (RST)
        (m_axi_arvalid && !m_axi_arready) |=> (m_axi_arvalid && $stable(m_axi_araddr)))
        else begin
            $error("AR request changed before arready");
            fail_count++;
        end

    ar_reset: assert property (@(posedge CLK) RST |=> !m_axi_arvalid)
        else begin
            $error("m_axi_arvalid high in the cycle after reset");
            fail_count++;
        end

    no_hit_in_fill: assert property (@(posedge CLK) disable iff (RST)
        !(rvalid && (fill_state != FILL_IDLE)))
        else begin
            $error("rvalid high while a page fill is running");
            fail_count++;
        end

    // Bursts never cross a 128-byte boundary
    ar_align: assert property (@(posedge CLK) disable iff (RST)
        m_axi_arvalid |-> ((m_axi_araddr % BURST_BYTES) == 0))
        else begin
            $error("m_axi_araddr not aligned to a burst");
            fail_count++;
        end

endmodule

bind cache_axi cache_axi_assert u_assert (
    .CLK           (CLK),
    .RST           (RST),
    .rvalid        (rvalid),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .fill_state    (u_fill.state)
);

`default_nettype wire

// File: bench/tb_cache_axi.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cache_axi
    import page_cache_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int NUM_HITS = 200;
    localparam int NUM_HIT_CHECKS = 40;
    localparam int NUM_PAGE_CHANGES = 4;
    localparam int HITS_PER_CHANGE = 10;
    localparam int NUM_FILLS = 1 + NUM_PAGE_CHANGES;
    localparam int NUM_READS = 4 + NUM_HITS + NUM_HIT_CHECKS
        + NUM_PAGE_CHANGES * (3 + HITS_PER_CHANGE);
    // Worst case is 4 cycles per beat plus AR slack for every burst
    localparam int WATCHDOG_NS = NUM_FILLS * BURSTS_PER_PAGE * (BURST_BEATS * 4 + 8)
        * CLK_PERIOD + NUM_READS * CLK_PERIOD;

    logic   CLK = 1'b0;
    logic   RST;
    logic   rden;
    addr_t  raddr;
    logic   rvalid;
    word_t  rdata;
    addr_t  hit_check_addr;
    logic   hit_check_result;
    addr_t  m_axi_araddr;
    logic   m_axi_arvalid;
    logic   m_axi_arready;
    word_t  m_axi_rdata;
    logic   m_axi_rlast;
    logic   m_axi_rvalid;
    word_t  key;

    // Reference model state
    page_t  model_page;
    logic   model_valid;
    addr_t  ar_q[$];
    int     beat_count;

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    cache_axi u_cache_axi (.*);

    axi_rd_mem_model u_mem (
        .CLK     (CLK),
        .RST     (RST),
        .key     (key),
        .araddr  (m_axi_araddr),
        .arvalid (m_axi_arvalid),
        .arready (m_axi_arready),
        .rdata   (m_axi_rdata),
        .rlast   (m_axi_rlast),
        .rvalid  (m_axi_rvalid)
    );

    task automatic end_with_failure();
        $display("** FAIL **");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            end_with_failure();
        end
    endtask

    function automatic page_t addr_page(input addr_t a);
        return a[ADDR_W-1:PAGE_OFS_W];
    endfunction

    function automatic addr_t page_base(input page_t p);
        return {p, {PAGE_OFS_W{1'b0}}};
    endfunction

    function automatic addr_t random_word_addr(input page_t p);
        return page_base(p) + addr_t'($urandom_range(0, WORDS_PER_PAGE - 1) * 4);
    endfunction

    // Bus monitor samples one negedge ahead of each accepting edge
    always @(negedge CLK) begin
        if (!RST && m_axi_arvalid && m_axi_arready) begin
            ar_q.push_back(m_axi_araddr);
        end
        if (!RST && m_axi_rvalid) begin
            beat_count++;
        end
        if (u_cache_axi.u_assert.fail_count != 0) begin
            $display("A concurrent assertion on the DUT failed");
            end_with_failure();
        end
    end

    // Called 1 ns after a rising edge and returns at the same point
    task automatic read_word(input addr_t addr);
        page_t page;
        page = addr_page(addr);
        rden = 1'b1;
        raddr = addr;
        if (model_valid && (page == model_page)) begin
            @(negedge CLK);
            check_bit("rvalid", rvalid, 1'b1);
        end else begin
            ar_q.delete();
            beat_count = 0;
            do begin
                @(negedge CLK);
            end while (!rvalid);
            if (beat_count != WORDS_PER_PAGE) begin
                $display("rvalid rose after %0d R beats instead of %0d",
                    beat_count, WORDS_PER_PAGE);
                end_with_failure();
            end
            if (ar_q.size() != BURSTS_PER_PAGE) begin
                $display("Page fill issued %0d AR requests instead of %0d",
                    ar_q.size(), BURSTS_PER_PAGE);
                end_with_failure();
            end
            for (int i = 0; i < BURSTS_PER_PAGE; i++) begin
                check_addr("m_axi_araddr", ar_q[i], page_base(page) + addr_t'(i * BURST_BYTES));
            end
            model_page = page;
            model_valid = 1'b1;
        end
        check_word("rdata", rdata, word_t'(addr) ^ key);
        @(posedge CLK);
        #1;
    endtask

    task automatic probe_hit(input addr_t addr);
        logic exp;
        exp = model_valid && (addr_page(addr) == model_page);
        hit_check_addr = addr;
        @(negedge CLK);
        check_bit("hit_check_result", hit_check_result, exp);
        @(posedge CLK);
        #1;
    endtask

    initial begin
        page_t old_page;
        page_t new_page;
        void'($urandom(14));
        key = $urandom();
        RST = 1'b1;
        rden = 1'b0;
        raddr = '0;
        hit_check_addr = '0;
        model_valid = 1'b0;
        model_page = '0;
        beat_count = 0;
        repeat (3) @(posedge CLK);
        #1;
        RST = 1'b0;

        @(negedge CLK);
        check_bit("m_axi_arvalid", m_axi_arvalid, 1'b0);
        @(posedge CLK);
        #1;
        repeat (3) probe_hit($urandom());

        // First fill and then hits in the resident page
        read_word(random_word_addr(page_t'($urandom())));
        repeat (NUM_HITS) read_word(random_word_addr(model_page));

        for (int i = 0; i < NUM_HIT_CHECKS; i++) begin
            if (i % 2 == 0) begin
                probe_hit(random_word_addr(model_page));
            end else begin
                probe_hit($urandom());
            end
        end

        for (int i = 0; i < NUM_PAGE_CHANGES; i++) begin
            old_page = model_page;
            do begin
                new_page = page_t'($urandom());
            end while (new_page == old_page);
            read_word(random_word_addr(new_page));
            probe_hit(random_word_addr(old_page));
            probe_hit(random_word_addr(new_page));
            repeat (HITS_PER_CHANGE) read_word(random_word_addr(model_page));
        end

        rden = 1'b0;
        @(negedge CLK);
        if (u_cache_axi.u_assert.fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("Concurrent assertions on the DUT failed during the run");
            end_with_failure();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run hung before all tests finished");
        end_with_failure();
    end

endmodule

`default_nettype wire

// File: list.f
common/page_cache_pkg.sv
page_cache/page_cache_ram.sv
page_cache/page_fill_ctrl.sv
src/cache_axi.sv
bench/axi_rd_mem_model.sv
bench/cache_axi_assert.sv
bench/tb_cache_axi.sv

// File: Bender.yml
package:
  name: page_cache

sources:
  # Design
  - common/page_cache_pkg.sv
  - page_cache/page_cache_ram.sv
  - page_cache/page_fill_ctrl.sv
  - src/cache_axi.sv

  # Simulation only
  - target: test
    files:
      - bench/axi_rd_mem_model.sv
      - bench/cache_axi_assert.sv
      - bench/tb_cache_axi.sv
